// File: logic/streamer_defines.svh
`ifndef STREAMER_DEFINES_SVH
`define STREAMER_DEFINES_SVH

// stream and memory data widths
`define STREAM_DW 32        // one stream word
`define MEM_DW    64        // stream word plus 32 spare bits for misalignment

// addressing
`define ADDR_W    32        // byte address
`define MEM_WORDS 256       // 64-bit words in the scratch memory

// timing and buffering
`define MEM_LAT   2         // grant to r_valid, no stall
`define OFS_DEPTH 4         // must cover MEM_LAT + 1 reads in flight

// counters
`define CNT_W     16        // lengths, strides, outstanding count

`endif

// File: logic/streamer_pkg.sv
`include "streamer_defines.svh"

package streamer_pkg;

  typedef logic [`ADDR_W-1:0]    addr_t;   // byte address
  typedef logic [`STREAM_DW-1:0] sword_t;  // stream word
  typedef logic [`MEM_DW-1:0]    mword_t;  // memory word, two halves
  typedef logic [`CNT_W-1:0]     cnt_t;    // length or count
  typedef logic [1:0]            ofs_t;    // byte offset in a 32-bit word

  typedef struct packed {
    addr_t base;     // first byte address
    cnt_t  len0;     // inner count
    cnt_t  len1;     // outer count
    cnt_t  stride0;  // inner byte step
    cnt_t  stride1;  // outer byte step
  } agen_ctrl_t;

  typedef struct packed {
    logic done;      // last address handed out
  } agen_flags_t;

  typedef struct packed {
    logic       req_start;  // start pulse, taken only when ready
    agen_ctrl_t agen;
  } src_ctrl_t;

  typedef struct packed {
    logic        ready_start;  // idle, start accepted
    logic        done;         // one-cycle end-of-run pulse
    agen_flags_t agen;
  } src_flags_t;

  typedef struct packed {
    logic  req;      // read request
    addr_t add;      // word-aligned byte address
    logic  r_ready;  // response accepted
  } mem_req_t;

  typedef struct packed {
    logic   gnt;     // request taken
    logic   r_valid; // response present
    mword_t r_data;  // bytes add .. add+7
  } mem_rsp_t;

  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_WORKING,
    SRC_DONE
  } src_state_e;

endpackage

// File: logic/addr_gen.sv
`timescale 1ns/10ps
`include "streamer_defines.svh"

module addr_gen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      enable_i,
  input  streamer_pkg::agen_ctrl_t  ctrl_i,
  output streamer_pkg::addr_t       addr_o,
  output logic                      addr_valid_o,
  input  logic                      addr_ready_i,
  output streamer_pkg::agen_flags_t flags_o
);

  streamer_pkg::agen_ctrl_t cfg_q;   // pattern captured at start
  streamer_pkg::cnt_t       i_q;     // inner index
  streamer_pkg::cnt_t       j_q;     // outer index
  streamer_pkg::addr_t      addr_q;  // current address
  streamer_pkg::addr_t      line_q;  // base + j * stride1
  logic                     valid_q;
  logic                     done_q;
  logic                     start;
  logic                     fire;
  logic                     last_i;
  logic                     last_j;

  assign start  = enable_i & ~valid_q & ~done_q;  // idle and enabled
  assign fire   = valid_q & addr_ready_i;
  assign last_i = (i_q == cfg_q.len0 - 1'b1);
  assign last_j = (j_q == cfg_q.len1 - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
      i_q     <= '0;
      j_q     <= '0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
      i_q     <= '0;
      j_q     <= '0;
    end else if (start) begin
      i_q     <= '0;
      j_q     <= '0;
      valid_q <= (ctrl_i.len0 != '0) && (ctrl_i.len1 != '0);
      done_q  <= (ctrl_i.len0 == '0) || (ctrl_i.len1 == '0);  // empty pattern
    end else if (fire) begin
      if (last_i && last_j) begin
        valid_q <= 1'b0;
        done_q  <= 1'b1;  // held until clear
      end else if (last_i) begin
        i_q <= '0;
        j_q <= j_q + 1'b1;
      end else begin
        i_q <= i_q + 1'b1;
      end
    end
  end

  // address arithmetic, incremental instead of multiplies
  always_ff @(posedge clk_i) begin
    if (start) begin
      cfg_q  <= ctrl_i;
      addr_q <= ctrl_i.base;
      line_q <= ctrl_i.base;
    end else if (fire && last_i) begin
      line_q <= line_q + `ADDR_W'(cfg_q.stride1);  // next row
      addr_q <= line_q + `ADDR_W'(cfg_q.stride1);
    end else if (fire) begin
      addr_q <= addr_q + `ADDR_W'(cfg_q.stride0);
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = valid_q;
  assign flags_o.done = done_q;

endmodule

// File: logic/stream_fifo.sv
`timescale 1ns/10ps
`include "streamer_defines.svh"

module stream_fifo #(
  parameter int unsigned WIDTH = `STREAM_DW,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             push_valid_i,
  input  logic [WIDTH-1:0] push_data_i,
  output logic             push_ready_o,
  output logic             pop_valid_o,
  output logic [WIDTH-1:0] pop_data_o,
  input  logic             pop_ready_i,
  output logic             empty_o
);

  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // pointer width
  localparam int unsigned CW = $clog2(DEPTH + 1);                 // count width

  logic [WIDTH-1:0] mem_q [DEPTH];  // storage, no reset
  logic [PW-1:0]    wr_ptr_q;
  logic [PW-1:0]    rd_ptr_q;
  logic [CW-1:0]    cnt_q;
  logic             push;
  logic             pop;

  function automatic logic [PW-1:0] ptr_inc(logic [PW-1:0] p);
    return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for any depth
  endfunction

  assign push_ready_o = (cnt_q != CW'(DEPTH));  // full blocks pushes
  assign pop_valid_o  = (cnt_q != '0);
  assign empty_o      = (cnt_q == '0);
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      cnt_q <= cnt_q + CW'(push) - CW'(pop);  // push and pop together keep the count
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

// File: logic/mem_source.sv
`timescale 1ns/10ps
`include "streamer_defines.svh"

module mem_source (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  streamer_pkg::src_ctrl_t  ctrl_i,
  output streamer_pkg::src_flags_t flags_o,
  output streamer_pkg::mem_req_t   mem_req_o,
  input  streamer_pkg::mem_rsp_t   mem_rsp_i,
  output logic                     stream_valid_o,
  input  logic                     stream_ready_i,
  output streamer_pkg::sword_t     stream_data_o
);

  streamer_pkg::src_state_e  state_q;
  streamer_pkg::src_state_e  state_d;
  streamer_pkg::agen_flags_t agen_flags;
  streamer_pkg::addr_t       agen_addr;
  streamer_pkg::addr_t       fifo_addr;   // head of the address FIFO
  streamer_pkg::ofs_t        ofs_head;    // offset of the word in hold_q
  streamer_pkg::mword_t      hold_q;      // response not yet streamed
  streamer_pkg::cnt_t        outst_q;     // granted but not streamed
  logic                      agen_en;
  logic                      agen_clr;
  logic                      finish;
  logic                      agen_valid;
  logic                      agen_ready;
  logic                      addr_valid;
  logic                      addr_empty;
  logic                      ofs_ready;
  logic                      req;
  logic                      req_fire;
  logic                      rsp_ready;
  logic                      rsp_fire;
  logic                      hold_valid_q;
  logic                      stream_fire;

  addr_gen u_agen (
    .clk_i        ( clk_i       ),
    .rst_ni       ( rst_ni      ),
    .clear_i      ( agen_clr    ),
    .enable_i     ( agen_en     ),
    .ctrl_i       ( ctrl_i.agen ),
    .addr_o       ( agen_addr   ),
    .addr_valid_o ( agen_valid  ),
    .addr_ready_i ( agen_ready  ),
    .flags_o      ( agen_flags  )
  );

  stream_fifo #(
    .WIDTH ( `ADDR_W ),
    .DEPTH ( 2       )
  ) u_addr_fifo (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .push_valid_i ( agen_valid ),
    .push_data_i  ( agen_addr  ),
    .push_ready_o ( agen_ready ),
    .pop_valid_o  ( addr_valid ),
    .pop_data_o   ( fifo_addr  ),
    .pop_ready_i  ( req_fire   ),  // popped on grant
    .empty_o      ( addr_empty )
  );

  // one offset per granted read, in response order
  stream_fifo #(
    .WIDTH ( $bits(streamer_pkg::ofs_t) ),
    .DEPTH ( `OFS_DEPTH                 )
  ) u_ofs_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( req_fire       ),
    .push_data_i  ( fifo_addr[1:0] ),
    .push_ready_o ( ofs_ready      ),
    .pop_valid_o  (                ),  // tracks hold_valid_q
    .pop_data_o   ( ofs_head       ),
    .pop_ready_i  ( stream_fire    ),
    .empty_o      (                )
  );

  assign req         = (state_q != streamer_pkg::SRC_IDLE) & addr_valid & stream_ready_i
                       & ofs_ready;  // no room for the offset, no request
  assign req_fire    = req & mem_rsp_i.gnt;
  assign rsp_ready   = ~hold_valid_q | stream_ready_i;  // hold free or draining
  assign rsp_fire    = mem_rsp_i.r_valid & rsp_ready;
  assign stream_fire = hold_valid_q & stream_ready_i;

  assign mem_req_o.req     = req;
  assign mem_req_o.add     = {fifo_addr[`ADDR_W-1:2], 2'b00};  // word aligned
  assign mem_req_o.r_ready = rsp_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (rsp_fire) begin
      hold_valid_q <= 1'b1;  // refill, possibly while draining
    end else if (stream_fire) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_fire) hold_q <= mem_rsp_i.r_data;
  end

  // window of bytes offset .. offset+3
  assign stream_data_o  = hold_q[{ofs_head, 3'b000} +: `STREAM_DW];
  assign stream_valid_o = hold_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
    end else if (clear_i) begin
      outst_q <= '0;
    end else if (req_fire && !stream_fire) begin
      outst_q <= outst_q + 1'b1;
    end else if (stream_fire && !req_fire) begin
      outst_q <= outst_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= streamer_pkg::SRC_IDLE;
    end else if (clear_i) begin
      state_q <= streamer_pkg::SRC_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    agen_en = 1'b0;
    finish  = 1'b0;
    unique case (state_q)
      streamer_pkg::SRC_IDLE: begin
        if (ctrl_i.req_start) begin
          agen_en = 1'b1;  // generator starts here
          state_d = streamer_pkg::SRC_WORKING;
        end
      end
      streamer_pkg::SRC_WORKING: begin
        agen_en = 1'b1;
        if (agen_flags.done) state_d = streamer_pkg::SRC_DONE;
      end
      streamer_pkg::SRC_DONE: begin
        agen_en = 1'b1;
        if (addr_empty && (outst_q == '0)) begin  // last word gone
          agen_en = 1'b0;
          finish  = 1'b1;
          state_d = streamer_pkg::SRC_IDLE;
        end
      end
      default: state_d = streamer_pkg::SRC_IDLE;
    endcase
  end

  assign agen_clr            = clear_i | finish;
  assign flags_o.ready_start = (state_q == streamer_pkg::SRC_IDLE);
  assign flags_o.done        = finish;
  assign flags_o.agen        = agen_flags;

endmodule

// File: logic/tcdm_mem.sv
`timescale 1ns/10ps
`include "streamer_defines.svh"

module tcdm_mem (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  streamer_pkg::mem_req_t mem_req_i,
  output streamer_pkg::mem_rsp_t mem_rsp_o,
  input  logic                   wr_en_i,
  input  streamer_pkg::addr_t    wr_addr_i,
  input  streamer_pkg::mword_t   wr_data_i
);

  localparam int          LAT    = `MEM_LAT;
  localparam int unsigned HALVES = 2 * `MEM_WORDS;  // 32-bit halves
  localparam int unsigned HW     = $clog2(HALVES);

  streamer_pkg::sword_t mem_q [HALVES];   // array of halves, no reset
  streamer_pkg::mword_t data_q [LAT];     // read pipeline payload
  logic [LAT-1:0]       vld_q;
  logic [LAT-1:0]       adv;              // stage may take new content
  logic [HW-1:0]        rd_lo;
  logic [HW-1:0]        rd_hi;
  logic [HW-2:0]        wr_word;
  logic                 rd_fire;

  assign rd_lo   = mem_req_i.add[HW+1:2];
  assign rd_hi   = rd_lo + 1'b1;           // wraps at the top of the array
  assign wr_word = wr_addr_i[HW+1:3];
  assign rd_fire = mem_req_i.req & adv[0];

  // a stage advances when the next one is empty or advancing
  always_comb begin
    adv[LAT-1] = ~vld_q[LAT-1] | mem_req_i.r_ready;
    for (int k = LAT - 2; k >= 0; k--) begin
      adv[k] = ~vld_q[k] | adv[k+1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_q <= '0;
    end else if (clear_i) begin
      vld_q <= '0;
    end else begin
      if (adv[0]) vld_q[0] <= mem_req_i.req;
      for (int k = 1; k < LAT; k++) begin
        if (adv[k]) vld_q[k] <= vld_q[k-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) data_q[0] <= {mem_q[rd_hi], mem_q[rd_lo]};  // little-endian pair
    for (int k = 1; k < LAT; k++) begin
      if (adv[k] && vld_q[k-1]) data_q[k] <= data_q[k-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[{wr_word, 1'b0}] <= wr_data_i[`STREAM_DW-1:0];
      mem_q[{wr_word, 1'b1}] <= wr_data_i[`MEM_DW-1:`STREAM_DW];
    end
  end

  assign mem_rsp_o.gnt     = adv[0];  // low only when stalled and full
  assign mem_rsp_o.r_valid = vld_q[LAT-1];
  assign mem_rsp_o.r_data  = data_q[LAT-1];

endmodule

// File: logic/stream_source_top.sv
`timescale 1ns/10ps
`include "streamer_defines.svh"

module stream_source_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  streamer_pkg::src_ctrl_t  ctrl_i,
  output streamer_pkg::src_flags_t flags_o,
  output logic                     stream_valid_o,
  input  logic                     stream_ready_i,
  output streamer_pkg::sword_t     stream_data_o,
  input  logic                     wr_en_i,
  input  streamer_pkg::addr_t      wr_addr_i,
  input  streamer_pkg::mword_t     wr_data_i
);

  streamer_pkg::mem_req_t mem_req;  // streamer to memory
  streamer_pkg::mem_rsp_t mem_rsp;  // memory to streamer

  mem_source u_src (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .ctrl_i         ( ctrl_i         ),
    .flags_o        ( flags_o        ),
    .mem_req_o      ( mem_req        ),
    .mem_rsp_i      ( mem_rsp        ),
    .stream_valid_o ( stream_valid_o ),
    .stream_ready_i ( stream_ready_i ),
    .stream_data_o  ( stream_data_o  )
  );

  // scratch memory, preload through the write port
  tcdm_mem u_mem (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear_i   ( clear_i   ),
    .mem_req_i ( mem_req   ),
    .mem_rsp_o ( mem_rsp   ),
    .wr_en_i   ( wr_en_i   ),
    .wr_addr_i ( wr_addr_i ),
    .wr_data_i ( wr_data_i )
  );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,  // clock period
  parameter int RST_CYCLES = 8     // cycles with reset low
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // released away from the active edge
  end

endmodule

// File: test/tb_stream_source.sv
`timescale 1ns/10ps
`include "streamer_defines.svh"

module tb_stream_source;

  logic                     clk;
  logic                     rst_n;
  logic                     clear;
  streamer_pkg::src_ctrl_t  ctrl;
  streamer_pkg::src_flags_t flags;
  logic                     s_valid;
  logic                     s_ready;
  streamer_pkg::sword_t     s_data;
  logic                     wr_en;
  streamer_pkg::addr_t      wr_addr;
  streamer_pkg::mword_t     wr_data;

  streamer_pkg::sword_t exp_q[$];  // reference words, oldest first
  streamer_pkg::sword_t data_prev;
  logic                 stall_prev;  // valid without ready last edge
  logic                 done_prev;
  int                   rx_cnt;
  int                   done_cnt;
  int                   err_cnt;
  int                   test_cnt;
  int                   fail_cnt;
  int                   run_done0;   // done count at run start
  int                   run_rx0;     // word count at run start
  bit                   timed_out;

  tb_clk_gen u_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  stream_source_top u_stream_source_top (
    .clk_i          ( clk     ),
    .rst_ni         ( rst_n   ),
    .clear_i        ( clear   ),
    .ctrl_i         ( ctrl    ),
    .flags_o        ( flags   ),
    .stream_valid_o ( s_valid ),
    .stream_ready_i ( s_ready ),
    .stream_data_o  ( s_data  ),
    .wr_en_i        ( wr_en   ),
    .wr_addr_i      ( wr_addr ),
    .wr_data_i      ( wr_data )
  );

  // byte b of the preloaded memory
  function automatic logic [7:0] byte_at(input streamer_pkg::addr_t b);
    return 8'(b * 7 + 3);
  endfunction

  function automatic streamer_pkg::sword_t expected_word(input streamer_pkg::addr_t a);
    return {byte_at(a + 3), byte_at(a + 2), byte_at(a + 1), byte_at(a)};  // little-endian
  endfunction

  function automatic streamer_pkg::mword_t mem_word(input streamer_pkg::addr_t a);
    streamer_pkg::mword_t w;
    for (int k = 0; k < 8; k++) begin
      w[8*k +: 8] = byte_at(a + streamer_pkg::addr_t'(k));
    end
    return w;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  // every transfer is compared against the head of the reference queue
  always @(posedge clk) begin : monitor
    streamer_pkg::sword_t exp_word;
    if (!rst_n || clear) begin
      stall_prev = 1'b0;
      done_prev  = 1'b0;
    end else begin
      if (stall_prev) begin
        assert (s_valid)
          else report_error("stream valid dropped before its word transferred");
        assert (s_data == data_prev)
          else report_error($sformatf("Mismatch stream_data_o held: expected %h, got %h",
                                      data_prev, s_data));
      end
      if (s_valid && s_ready) begin
        rx_cnt++;
        assert (exp_q.size() != 0)
          else report_error($sformatf("stream word %h arrived with none expected", s_data));
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          assert (s_data == exp_word)
            else report_error($sformatf("Mismatch stream_data_o: expected %h, got %h",
                                        exp_word, s_data));
        end
      end
      if (flags.done) begin
        done_cnt++;
        assert (!done_prev) else report_error("done stayed high for more than one cycle");
        assert (flags.agen.done)
          else report_error("Mismatch flags_o.agen.done at done: expected 1, got 0");
      end
      stall_prev = s_valid & ~s_ready;
      data_prev  = s_data;
      done_prev  = flags.done;
    end
  end

  task automatic wait_reset();
    int cyc;
    cyc = 0;
    while (!rst_n && cyc < 20) begin
      @(negedge clk);
      cyc++;
    end
    if (!rst_n) begin
      $display("timeout while waiting for reset release");
      timed_out = 1'b1;
    end
  endtask

  task automatic preload_memory();
    for (int w = 0; w < `MEM_WORDS; w++) begin
      wr_en   = 1'b1;
      wr_addr = streamer_pkg::addr_t'(w * 8);
      wr_data = mem_word(streamer_pkg::addr_t'(w * 8));
      @(negedge clk);
    end
    wr_en = 1'b0;
  endtask

  // outer-then-inner order like the generator
  task automatic load_expected(input streamer_pkg::addr_t base, input int len0, input int len1,
                               input int stride0, input int stride1);
    streamer_pkg::addr_t a;
    for (int j = 0; j < len1; j++) begin
      for (int i = 0; i < len0; i++) begin
        a = base + streamer_pkg::addr_t'(j * stride1 + i * stride0);
        exp_q.push_back(expected_word(a));
      end
    end
  endtask

  task automatic start_run(input streamer_pkg::addr_t base, input int len0, input int len1,
                           input int stride0, input int stride1);
    int cyc;
    cyc = 0;
    while (!flags.ready_start && cyc < 50) begin
      @(negedge clk);
      cyc++;
    end
    if (!flags.ready_start) begin
      $display("timeout while waiting for ready_start before a run");
      timed_out = 1'b1;
      return;
    end
    run_done0              = done_cnt;
    run_rx0                = rx_cnt;
    ctrl.agen.base         = base;
    ctrl.agen.len0         = streamer_pkg::cnt_t'(len0);
    ctrl.agen.len1         = streamer_pkg::cnt_t'(len1);
    ctrl.agen.stride0      = streamer_pkg::cnt_t'(stride0);
    ctrl.agen.stride1      = streamer_pkg::cnt_t'(stride1);
    ctrl.req_start         = 1'b1;  // one-cycle start
    @(negedge clk);
    ctrl.req_start         = 1'b0;
    assert (!flags.agen.done)
      else report_error("Mismatch flags_o.agen.done after start: expected 0, got 1");
  endtask

  task automatic finish_run(input int n, input bit rand_ready);
    int cyc;
    int first_cyc;
    cyc       = 0;
    first_cyc = -1;
    while (done_cnt == run_done0 && cyc < 20 * n + 100) begin
      if (rand_ready) s_ready = 1'($urandom & 32'd1);  // about half the cycles
      @(negedge clk);
      cyc++;
      if (first_cyc < 0 && rx_cnt != run_rx0) first_cyc = cyc;
    end
    s_ready = 1'b1;
    if (done_cnt == run_done0) begin
      $display("timeout while waiting for done after %0d words", rx_cnt - run_rx0);
      timed_out = 1'b1;
      return;
    end
    assert (flags.ready_start)
      else report_error("Mismatch flags_o.ready_start after done: expected 1, got 0");
    assert (!flags.agen.done)
      else report_error("Mismatch flags_o.agen.done after done: expected 0, got 1");
    assert (rx_cnt - run_rx0 == n)
      else report_error($sformatf("Mismatch word count: expected %h, got %h",
                                  n, rx_cnt - run_rx0));
    assert (exp_q.size() == 0)
      else report_error($sformatf("%0d expected words never arrived", exp_q.size()));
    if (!rand_ready) begin
      assert (first_cyc > 0 && first_cyc <= 6)
        else report_error($sformatf("first word came %0d cycles after start", first_cyc));
      assert (cyc <= n + 8)
        else report_error($sformatf("run of %0d words took %0d cycles", n, cyc));
    end
    for (int k = 0; k < 3; k++) @(negedge clk);  // no second done pulse
    assert (done_cnt == run_done0 + 1)
      else report_error($sformatf("Mismatch done pulses: expected %h, got %h",
                                  1, done_cnt - run_done0));
  endtask

  task automatic run_pattern(input streamer_pkg::addr_t base, input int len0, input int len1,
                             input int stride0, input int stride1, input bit rand_ready);
    load_expected(base, len0, len1, stride0, stride1);
    start_run(base, len0, len1, stride0, stride1);
    if (!timed_out) finish_run(len0 * len1, rand_ready);
  endtask

  task automatic clear_mid_run();
    int cyc;
    load_expected(32'h600, 30, 1, 4, 0);
    start_run(32'h600, 30, 1, 4, 0);
    if (timed_out) return;
    cyc = 0;
    while (rx_cnt - run_rx0 < 5 && cyc < 50) begin
      @(negedge clk);
      cyc++;
    end
    if (rx_cnt - run_rx0 < 5) begin
      $display("timeout while waiting for words before clear");
      timed_out = 1'b1;
      return;
    end
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    exp_q.delete();  // rest of the run is dropped
    assert (flags.ready_start)
      else report_error("Mismatch flags_o.ready_start after clear: expected 1, got 0");
    assert (!s_valid)
      else report_error($sformatf("Mismatch stream_valid_o after clear: expected 0, got %h",
                                  s_valid));
    assert (done_cnt == run_done0) else report_error("done pulsed for a cleared run");
    run_pattern(32'h680, 12, 1, 4, 0, 1'b0);
  endtask

  task automatic end_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt != err_before || timed_out) begin
      fail_cnt++;
      $display("%s: failed", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  initial begin
    int seed_val;
    int e0;
    clear     = 1'b0;
    ctrl      = '0;
    s_ready   = 1'b1;
    wr_en     = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    rx_cnt    = 0;
    done_cnt  = 0;
    err_cnt   = 0;
    test_cnt  = 0;
    fail_cnt  = 0;
    timed_out = 1'b0;
    stall_prev = 1'b0;
    done_prev  = 1'b0;
    seed_val  = $urandom(32'h2c4494c5);
    wait_reset();
    if (!timed_out) preload_memory();
    if (!timed_out) begin
      e0 = err_cnt;
      assert (flags.ready_start)
        else report_error("Mismatch flags_o.ready_start: expected 1, got 0");
      assert (!flags.done)
        else report_error($sformatf("Mismatch flags_o.done: expected 0, got %h", flags.done));
      assert (!flags.agen.done)
        else report_error($sformatf("Mismatch flags_o.agen.done: expected 0, got %h",
                                    flags.agen.done));
      assert (!s_valid)
        else report_error($sformatf("Mismatch stream_valid_o: expected 0, got %h", s_valid));
      assert (!u_stream_source_top.mem_req.req)
        else report_error("memory request raised while idle");
      end_test("reset state", e0);
    end
    if (!timed_out) begin
      e0 = err_cnt;
      run_pattern(32'h40, 16, 1, 4, 0, 1'b0);
      end_test("aligned 1-D run", e0);
    end
    if (!timed_out) begin
      e0 = err_cnt;
      run_pattern(32'h101, 8, 1, 4, 0, 1'b0);
      if (!timed_out) run_pattern(32'h202, 8, 1, 4, 0, 1'b0);
      if (!timed_out) run_pattern(32'h303, 8, 1, 4, 0, 1'b0);
      end_test("misaligned runs", e0);
    end
    if (!timed_out) begin
      e0 = err_cnt;
      run_pattern(32'h400, 4, 3, 8, 100, 1'b0);
      end_test("2-D run", e0);
    end
    if (!timed_out) begin
      e0 = err_cnt;
      run_pattern(32'h502, 40, 1, 4, 0, 1'b1);  // random back-pressure
      end_test("random ready run", e0);
    end
    if (!timed_out) begin
      e0 = err_cnt;
      clear_mid_run();
      end_test("clear mid-run", e0);
    end
    $display("tests %0d, failed %0d, words %0d, errors %0d, timeout %0d",
             test_cnt, fail_cnt, rx_cnt, err_cnt, timed_out);
    if (err_cnt == 0 && !timed_out && test_cnt == 6) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+logic
logic/streamer_pkg.sv
logic/addr_gen.sv
logic/stream_fifo.sv
logic/mem_source.sv
logic/tcdm_mem.sv
logic/stream_source_top.sv
test/tb_clk_gen.sv
test/tb_stream_source.sv
